// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // Core widths
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    // Instruction buffer geometry
    localparam int IB_DEPTH = 8;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);
    localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);

    // Front-end PC tagging
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c000000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_NOP
    } alu_op_e;

    // 3R-type major opcodes, instr[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12-type, instr[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;

    // 1RI20-type, instr[31:25]
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

endpackage

`default_nettype wire

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic            clk,
    input  wire logic            rst_i,
    input  wire logic            instr_valid_i,
    input  wire core_pkg::word_t instr_i,
    input  wire logic            hold_i,
    output logic                 instr_ready_o,
    output logic                 debug_wb_valid_o,
    output core_pkg::word_t      debug_wb_pc_o,
    output logic                 debug_wb_rf_wen_o,
    output core_pkg::reg_addr_t  debug_wb_rf_wnum_o,
    output core_pkg::word_t      debug_wb_rf_wdata_o
);

    logic                ib_push;
    logic                ib_pop;
    logic                head_valid;
    core_pkg::word_t     head_instr;
    core_pkg::word_t     head_pc;
    core_pkg::reg_addr_t raddr_a;
    core_pkg::reg_addr_t raddr_b;
    core_pkg::word_t     rdata_a;
    core_pkg::word_t     rdata_b;

    issue_if issue ();
    wb_if    ex_res ();
    wb_if    wb ();

    // Accept on valid and ready
    assign ib_push = instr_valid_i && instr_ready_o;

    instr_buffer u_instr_buffer (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (ib_push),
        .instr_i     (instr_i),
        .pop_i       (ib_pop),
        .ready_o     (instr_ready_o),
        .head_valid_o(head_valid),
        .head_instr_o(head_instr),
        .head_pc_o   (head_pc)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb       (wb.rf),
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b)
    );

    decode_dispatch u_decode_dispatch (
        .clk         (clk),
        .rst_i       (rst_i),
        .hold_i      (hold_i),
        .head_valid_i(head_valid),
        .head_instr_i(head_instr),
        .head_pc_i   (head_pc),
        .pop_o       (ib_pop),
        .raddr_a_o   (raddr_a),
        .raddr_b_o   (raddr_b),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .ex_fwd      (ex_res.fwd),
        .wb_fwd      (wb.fwd),
        .issue       (issue.dispatch)
    );

    exec_unit u_exec_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .hold_i       (hold_i),
        .issue        (issue.execute),
        .ex_res       (ex_res.exec),
        .wb           (wb.exec),
        .debug_valid_o(debug_wb_valid_o)
    );

    // Writeback trace
    assign debug_wb_pc_o       = wb.pc;
    assign debug_wb_rf_wen_o   = wb.wen;
    assign debug_wb_rf_wnum_o  = wb.waddr;
    assign debug_wb_rf_wdata_o = wb.wdata;

endmodule

`default_nettype wire

// File: hdl/decode_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module decode_dispatch (
    input  wire logic                clk,
    input  wire logic                rst_i,
    input  wire logic                hold_i,
    input  wire logic                head_valid_i,
    input  wire core_pkg::word_t     head_instr_i,
    input  wire core_pkg::word_t     head_pc_i,
    output logic                     pop_o,
    output core_pkg::reg_addr_t      raddr_a_o,
    output core_pkg::reg_addr_t      raddr_b_o,
    input  wire core_pkg::word_t     rdata_a_i,
    input  wire core_pkg::word_t     rdata_b_i,
    wb_if.fwd                        ex_fwd,
    wb_if.fwd                        wb_fwd,
    issue_if.dispatch                issue
);

    core_pkg::reg_addr_t rd;
    core_pkg::alu_op_e   dec_op;
    logic                dec_wen;
    logic                dec_use_imm;
    logic                dec_zero_a;
    core_pkg::word_t     dec_imm;
    core_pkg::word_t     opnd_a;
    core_pkg::word_t     opnd_b;

    // Dispatch register
    logic                valid_q;
    logic                wen_q;
    core_pkg::word_t     pc_q;
    core_pkg::alu_op_e   op_q;
    core_pkg::reg_addr_t rd_q;
    core_pkg::word_t     src_a_q;
    core_pkg::word_t     src_b_q;

    // LoongArch fields: rd[4:0], rj[9:5], rk[14:10]
    assign rd        = head_instr_i[4:0];
    assign raddr_a_o = head_instr_i[9:5];
    assign raddr_b_o = head_instr_i[14:10];

    always_comb begin
        dec_op      = core_pkg::ALU_NOP;
        dec_wen     = 1'b0;
        dec_use_imm = 1'b0;
        dec_zero_a  = 1'b0;
        dec_imm     = '0;
        if (head_instr_i[31:15] == core_pkg::OPC_ADD_W) begin
            dec_op  = core_pkg::ALU_ADD;
            dec_wen = 1'b1;
        end else if (head_instr_i[31:15] == core_pkg::OPC_SUB_W) begin
            dec_op  = core_pkg::ALU_SUB;
            dec_wen = 1'b1;
        end else if (head_instr_i[31:15] == core_pkg::OPC_AND) begin
            dec_op  = core_pkg::ALU_AND;
            dec_wen = 1'b1;
        end else if (head_instr_i[31:15] == core_pkg::OPC_OR) begin
            dec_op  = core_pkg::ALU_OR;
            dec_wen = 1'b1;
        end else if (head_instr_i[31:15] == core_pkg::OPC_XOR) begin
            dec_op  = core_pkg::ALU_XOR;
            dec_wen = 1'b1;
        end else if (head_instr_i[31:22] == core_pkg::OPC_ADDI_W) begin
            // si12 sign-extended
            dec_op      = core_pkg::ALU_ADD;
            dec_wen     = 1'b1;
            dec_use_imm = 1'b1;
            dec_imm     = {{20{head_instr_i[21]}}, head_instr_i[21:10]};
        end else if (head_instr_i[31:25] == core_pkg::OPC_LU12I_W) begin
            // si20 into the upper bits, rj field is part of the immediate
            dec_op      = core_pkg::ALU_LUI;
            dec_wen     = 1'b1;
            dec_use_imm = 1'b1;
            dec_zero_a  = 1'b1;
            dec_imm     = {head_instr_i[24:5], 12'h000};
        end
        if (rd == '0) begin
            dec_wen = 1'b0;
        end
    end

    // Execute result first, then writeback, then the register file
    function automatic core_pkg::word_t resolve(
        input core_pkg::reg_addr_t addr,
        input core_pkg::word_t     rf_data
    );
        core_pkg::word_t data;
        if (ex_fwd.valid && ex_fwd.wen && (ex_fwd.waddr == addr)) begin
            data = ex_fwd.wdata;
        end else if (wb_fwd.valid && wb_fwd.wen && (wb_fwd.waddr == addr)) begin
            data = wb_fwd.wdata;
        end else begin
            data = rf_data;
        end
        return data;
    endfunction

    always_comb begin
        opnd_a = dec_zero_a ? '0 : resolve(raddr_a_o, rdata_a_i);
        opnd_b = dec_use_imm ? dec_imm : resolve(raddr_b_o, rdata_b_i);
    end

    assign pop_o = head_valid_i && !hold_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= head_valid_i;
            wen_q   <= head_valid_i && dec_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            pc_q    <= head_pc_i;
            op_q    <= dec_op;
            rd_q    <= rd;
            src_a_q <= opnd_a;
            src_b_q <= opnd_b;
        end
    end

    assign issue.valid  = valid_q;
    assign issue.wen    = wen_q;
    assign issue.pc     = pc_q;
    assign issue.alu_op = op_q;
    assign issue.rd     = rd_q;
    assign issue.src_a  = src_a_q;
    assign issue.src_b  = src_b_q;

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic  clk,
    input  wire logic  rst_i,
    input  wire logic  hold_i,
    issue_if.execute   issue,
    wb_if.exec         ex_res,
    wb_if.exec         wb,
    output logic       debug_valid_o
);

    core_pkg::word_t     alu_res;

    // Writeback register
    logic                wb_valid_q;
    logic                wb_wen_q;
    core_pkg::word_t     wb_pc_q;
    core_pkg::reg_addr_t wb_waddr_q;
    core_pkg::word_t     wb_wdata_q;

    always_comb begin
        case (issue.alu_op)
            core_pkg::ALU_ADD: alu_res = issue.src_a + issue.src_b;
            core_pkg::ALU_SUB: alu_res = issue.src_a - issue.src_b;
            core_pkg::ALU_AND: alu_res = issue.src_a & issue.src_b;
            core_pkg::ALU_OR:  alu_res = issue.src_a | issue.src_b;
            core_pkg::ALU_XOR: alu_res = issue.src_a ^ issue.src_b;
            core_pkg::ALU_LUI: alu_res = issue.src_b;
            core_pkg::ALU_NOP: alu_res = '0;
            default:           alu_res = '0;
        endcase
    end

    // Bypass path back to dispatch
    assign ex_res.valid = issue.valid;
    assign ex_res.pc    = issue.pc;
    assign ex_res.wen   = issue.wen;
    assign ex_res.waddr = issue.rd;
    assign ex_res.wdata = alu_res;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_q <= 1'b0;
            wb_wen_q   <= 1'b0;
        end else if (!hold_i) begin
            wb_valid_q <= issue.valid;
            wb_wen_q   <= issue.valid && issue.wen;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            wb_pc_q    <= issue.pc;
            wb_waddr_q <= issue.rd;
            wb_wdata_q <= alu_res;
        end
    end

    // A held result retires once, after hold drops
    assign wb.valid      = wb_valid_q && !hold_i;
    assign debug_valid_o = wb_valid_q && !hold_i;
    assign wb.pc         = wb_pc_q;
    assign wb.wen        = wb_wen_q;
    assign wb.waddr      = wb_waddr_q;
    assign wb.wdata      = wb_wdata_q;

    // Every retired instruction carries a PC stamped by the buffer
    a_pc_known: assert property (
        @(posedge clk) disable iff (rst_i) debug_valid_o |-> !$isunknown(wb.pc)
    );

endmodule

`default_nettype wire

// File: hdl/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer (
    input  wire logic            clk,
    input  wire logic            rst_i,
    input  wire logic            push_i,
    input  wire core_pkg::word_t instr_i,
    input  wire logic            pop_i,
    output logic                 ready_o,
    output logic                 head_valid_o,
    output core_pkg::word_t      head_instr_o,
    output core_pkg::word_t      head_pc_o
);

    core_pkg::word_t instr_mem [core_pkg::IB_DEPTH];
    core_pkg::word_t pc_mem    [core_pkg::IB_DEPTH];

    logic [core_pkg::IB_PTR_W-1:0] wr_ptr;
    logic [core_pkg::IB_PTR_W-1:0] rd_ptr;
    logic [core_pkg::IB_CNT_W-1:0] count;
    core_pkg::word_t               pc_cnt;

    assign ready_o      = (count != core_pkg::IB_DEPTH);
    assign head_valid_o = (count != '0);
    assign head_instr_o = instr_mem[rd_ptr];
    assign head_pc_o    = pc_mem[rd_ptr];

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pc_cnt <= core_pkg::RESET_PC;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
                pc_cnt <= pc_cnt + core_pkg::PC_STEP;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage, each word tagged with its PC
    always_ff @(posedge clk) begin
        if (push_i) begin
            instr_mem[wr_ptr] <= instr_i;
            pc_mem[wr_ptr]    <= pc_cnt;
        end
    end

    // Top level must gate the strobe with ready
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst_i) push_i |-> ready_o
    );

    // Dispatch only takes a live head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst_i) pop_i |-> head_valid_o
    );

endmodule

`default_nettype wire

// File: hdl/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;

    logic                valid;
    core_pkg::word_t     pc;
    core_pkg::alu_op_e   alu_op;
    core_pkg::reg_addr_t rd;
    logic                wen;
    core_pkg::word_t     src_a;
    core_pkg::word_t     src_b;

    // Dispatch register side
    modport dispatch (
        output valid, pc, alu_op, rd, wen, src_a, src_b
    );

    // ALU side
    modport execute (
        input valid, pc, alu_op, rd, wen, src_a, src_b
    );

endinterface

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                clk,
    input  wire logic                rst_i,
    wb_if.rf                         wb,
    input  wire core_pkg::reg_addr_t raddr_a_i,
    input  wire core_pkg::reg_addr_t raddr_b_i,
    output core_pkg::word_t          rdata_a_o,
    output core_pkg::word_t          rdata_b_o
);

    // r0 has no storage
    core_pkg::word_t regs [1:core_pkg::NUM_REGS-1];
    logic            wr_en;

    assign wr_en = wb.valid && wb.wen && (wb.waddr != '0);

    function automatic core_pkg::word_t read_port(
        input core_pkg::reg_addr_t addr,
        input core_pkg::word_t     stored,
        input logic                we,
        input core_pkg::reg_addr_t waddr,
        input core_pkg::word_t     wdata
    );
        core_pkg::word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (we && (addr == waddr)) begin
            // Same-cycle write is seen by the reader
            data = wdata;
        end else begin
            data = stored;
        end
        return data;
    endfunction

    assign rdata_a_o = read_port(raddr_a_i, regs[raddr_a_i], wr_en, wb.waddr, wb.wdata);
    assign rdata_b_o = read_port(raddr_b_i, regs[raddr_b_i], wr_en, wb.waddr, wb.wdata);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // Decode clears wen for rd == 0, so no such write reaches here
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (rst_i) !(wb.valid && wb.wen && (wb.waddr == '0))
    );

endmodule

`default_nettype wire

// File: hdl/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    logic                valid;
    core_pkg::word_t     pc;
    logic                wen;
    core_pkg::reg_addr_t waddr;
    core_pkg::word_t     wdata;

    modport exec (
        output valid, pc, wen, waddr, wdata
    );

    // Register file write port
    modport rf (
        input valid, pc, wen, waddr, wdata
    );

    // Bypass source for dispatch
    modport fwd (
        input valid, pc, wen, waddr, wdata
    );

endinterface

`default_nettype wire

// File: mini_core.f
hdl/core_pkg.sv
hdl/issue_if.sv
hdl/wb_if.sv
hdl/instr_buffer.sv
hdl/regfile.sv
hdl/decode_dispatch.sv
hdl/exec_unit.sv
hdl/cpu_top.sv
verification/tb_cpu_top.sv

// File: verification/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam int CLK_HALF   = 4;
    localparam int N_DIRECTED = 7;
    localparam int N_RANDOM   = 150;
    localparam int N_CHAIN    = 100;
    localparam int N_MIXED    = 100;
    localparam int N_PLANNED  = N_DIRECTED + N_RANDOM + 2 * N_CHAIN + core_pkg::IB_DEPTH
                                + 2 * N_MIXED;
    localparam int WATCHDOG_CYCLES = 40 * N_PLANNED;
    // A full buffer plus two stages drains well within this
    localparam int DRAIN_CYCLES = 8 * core_pkg::IB_DEPTH;

    typedef struct packed {
        core_pkg::word_t     pc;
        logic                wen;
        core_pkg::reg_addr_t wnum;
        core_pkg::word_t     wdata;
    } exp_t;

    logic                clk = 1'b0;
    logic                rst_i;
    logic                instr_valid_i;
    core_pkg::word_t     instr_i;
    logic                hold_i;
    logic                instr_ready_o;
    logic                debug_wb_valid_o;
    core_pkg::word_t     debug_wb_pc_o;
    logic                debug_wb_rf_wen_o;
    core_pkg::reg_addr_t debug_wb_rf_wnum_o;
    core_pkg::word_t     debug_wb_rf_wdata_o;

    integer              seed = 32'h86b6698d;
    core_pkg::word_t     model_rf [core_pkg::NUM_REGS];
    core_pkg::word_t     pc_model = core_pkg::RESET_PC;
    core_pkg::reg_addr_t last_rd = '0;
    exp_t                exp_q [$];

    cpu_top cpu_top_i (
        .clk                (clk),
        .rst_i              (rst_i),
        .instr_valid_i      (instr_valid_i),
        .instr_i            (instr_i),
        .hold_i             (hold_i),
        .instr_ready_o      (instr_ready_o),
        .debug_wb_valid_o   (debug_wb_valid_o),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic core_pkg::word_t enc_3r(input logic [16:0] opc,
                                               input core_pkg::reg_addr_t rk,
                                               input core_pkg::reg_addr_t rj,
                                               input core_pkg::reg_addr_t rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic core_pkg::word_t enc_addi(input logic [11:0] si12,
                                                 input core_pkg::reg_addr_t rj,
                                                 input core_pkg::reg_addr_t rd);
        return {core_pkg::OPC_ADDI_W, si12, rj, rd};
    endfunction

    function automatic core_pkg::word_t enc_lu12i(input logic [19:0] si20,
                                                  input core_pkg::reg_addr_t rd);
        return {core_pkg::OPC_LU12I_W, si20, rd};
    endfunction

    // Architectural effect of one word on the model register file
    function automatic exp_t ref_exec(input core_pkg::word_t instr);
        exp_t            e;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t res;
        logic            known;
        a     = model_rf[instr[9:5]];
        b     = model_rf[instr[14:10]];
        res   = '0;
        known = 1'b1;
        if (instr[31:15] == core_pkg::OPC_ADD_W) begin
            res = a + b;
        end else if (instr[31:15] == core_pkg::OPC_SUB_W) begin
            res = a - b;
        end else if (instr[31:15] == core_pkg::OPC_AND) begin
            res = a & b;
        end else if (instr[31:15] == core_pkg::OPC_OR) begin
            res = a | b;
        end else if (instr[31:15] == core_pkg::OPC_XOR) begin
            res = a ^ b;
        end else if (instr[31:22] == core_pkg::OPC_ADDI_W) begin
            res = a + {{20{instr[21]}}, instr[21:10]};
        end else if (instr[31:25] == core_pkg::OPC_LU12I_W) begin
            res = {instr[24:5], 12'h000};
        end else begin
            known = 1'b0;
        end
        e.pc    = '0;
        e.wen   = known && (instr[4:0] != 5'd0);
        e.wnum  = instr[4:0];
        e.wdata = res;
        if (e.wen) begin
            model_rf[instr[4:0]] = res;
        end
        return e;
    endfunction

    function automatic void record_accept(input core_pkg::word_t instr);
        exp_t e;
        e = ref_exec(instr);
        e.pc = pc_model;
        pc_model = pc_model + 32'd4;
        exp_q.push_back(e);
    endfunction

    // Small register range keeps dependencies frequent
    function automatic core_pkg::word_t gen_instr(input bit chain);
        int                  kind;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rj;
        core_pkg::reg_addr_t rk;
        core_pkg::word_t     w;
        kind = rand_below(8);
        rd   = core_pkg::reg_addr_t'(rand_below(8));
        rj   = chain ? last_rd : core_pkg::reg_addr_t'(rand_below(8));
        rk   = (chain && rand_below(2) == 0) ? last_rd : core_pkg::reg_addr_t'(rand_below(8));
        case (kind)
            0:       w = enc_3r(core_pkg::OPC_ADD_W, rk, rj, rd);
            1:       w = enc_3r(core_pkg::OPC_SUB_W, rk, rj, rd);
            2:       w = enc_3r(core_pkg::OPC_AND, rk, rj, rd);
            3:       w = enc_3r(core_pkg::OPC_OR, rk, rj, rd);
            4:       w = enc_3r(core_pkg::OPC_XOR, rk, rj, rd);
            5:       w = enc_addi(12'(rand_below(4096)), rj, rd);
            6:       w = enc_lu12i(20'($random(seed)), rd);
            // Top byte 0xff matches no supported opcode
            default: w = {8'hff, 24'($random(seed))};
        endcase
        last_rd = rd;
        return w;
    endfunction

    task automatic send_one(input core_pkg::word_t w);
        instr_valid_i <= 1'b1;
        instr_i       <= w;
        @(posedge clk);
        while (!instr_ready_o) begin
            @(posedge clk);
        end
        record_accept(w);
        instr_valid_i <= 1'b0;
    endtask

    task automatic drive_stream(input int count, input int valid_pct, input int hold_pct,
                                input bit chain);
        int              sent;
        core_pkg::word_t next;
        sent = 0;
        next = gen_instr(chain);
        while (sent < count) begin
            @(posedge clk);
            if (instr_valid_i && instr_ready_o) begin
                record_accept(instr_i);
                sent++;
                next = gen_instr(chain);
            end
            if ((sent < count) && (rand_below(100) < valid_pct)) begin
                instr_valid_i <= 1'b1;
                instr_i       <= next;
            end else begin
                instr_valid_i <= 1'b0;
            end
            hold_i <= (rand_below(100) < hold_pct);
        end
        hold_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited        = 0;
        hold_i        <= 1'b0;
        instr_valid_i <= 1'b0;
        while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
    endtask

    // Empty pipeline, no hold, so retirement shows two edges after acceptance
    task automatic check_latency();
        send_one(enc_addi(12'h7ff, 5'd0, 5'd1));
        @(posedge clk);
        check_value("debug_wb_valid_o", 32'd0, debug_wb_valid_o);
        @(posedge clk);
        check_value("debug_wb_valid_o", 32'd0, debug_wb_valid_o);
        @(posedge clk);
        check_value("debug_wb_valid_o", 32'd1, debug_wb_valid_o);
    endtask

    task automatic check_r0();
        send_one(enc_lu12i(20'habcde, 5'd7));
        send_one(enc_addi(12'h005, 5'd0, 5'd0));
        send_one(32'hffffffff);
        send_one(enc_lu12i(20'h12345, 5'd0));
        send_one(enc_3r(core_pkg::OPC_ADD_W, 5'd0, 5'd0, 5'd7));
        send_one(enc_3r(core_pkg::OPC_OR, 5'd0, 5'd7, 5'd8));
        wait_drain();
    endtask

    task automatic hold_fill();
        int accepted;
        accepted      = 0;
        hold_i        <= 1'b1;
        instr_valid_i <= 1'b1;
        instr_i       <= gen_instr(1'b0);
        repeat (2 * core_pkg::IB_DEPTH) begin
            @(posedge clk);
            check_value("debug_wb_valid_o", 32'd0, debug_wb_valid_o);
            if (instr_valid_i && instr_ready_o) begin
                record_accept(instr_i);
                accepted++;
                instr_i <= gen_instr(1'b0);
            end
        end
        check_value("instr_ready_o", 32'd0, instr_ready_o);
        check_value("accepted count", core_pkg::IB_DEPTH, accepted);
        wait_drain();
    endtask

    always @(posedge clk) begin : retire_check
        exp_t e;
        if (!rst_i && debug_wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Retirement seen while no accepted instruction is outstanding");
                $display("Simulation FAILED");
                $fatal(1, "unexpected retirement");
            end else begin
                e = exp_q.pop_front();
                check_value("debug_wb_pc_o", e.pc, debug_wb_pc_o);
                check_value("debug_wb_rf_wen_o", 32'(e.wen), debug_wb_rf_wen_o);
                // Number and data only carry meaning for a real write
                if (e.wen) begin
                    check_value("debug_wb_rf_wnum_o", 32'(e.wnum), debug_wb_rf_wnum_o);
                    check_value("debug_wb_rf_wdata_o", e.wdata, debug_wb_rf_wdata_o);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d retirements still missing",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        hold_i        = 1'b0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("instr_ready_o", 32'd1, instr_ready_o);
        check_value("debug_wb_valid_o", 32'd0, debug_wb_valid_o);
        repeat (4) @(posedge clk);

        check_latency();
        check_r0();
        drive_stream(N_RANDOM, 100, 0, 1'b0);
        wait_drain();
        // Back-to-back chain uses the execute bypass, gaps use writeback
        drive_stream(N_CHAIN, 100, 0, 1'b1);
        wait_drain();
        drive_stream(N_CHAIN, 50, 0, 1'b1);
        wait_drain();
        hold_fill();
        drive_stream(N_MIXED, 60, 30, 1'b0);
        wait_drain();
        drive_stream(N_MIXED, 70, 25, 1'b1);
        wait_drain();

        if (exp_q.size() != 0) begin
            $display("%0d accepted instructions never retired", exp_q.size());
            $display("Simulation FAILED");
            $fatal(1, "missing retirements");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
